//--- reflex_macros.svh
`ifndef REFLEX_MACROS_SVH
`define REFLEX_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// bus and datapath widths
//////////////////////////////////////////////////////////////////////

// data words, synaptic currents and membrane
`define REFLEX_DATA_W 32

// register address on the wishbone bus
`define REFLEX_ADR_W 2

//////////////////////////////////////////////////////////////////////
// register reset values
//////////////////////////////////////////////////////////////////////

// unity synaptic gain
`define REFLEX_GAIN_RST 32'sd1

// firing threshold of the motor neuron
`define REFLEX_THRESH_RST 32'sd4096

// counting window in ep50trig cycles
`define REFLEX_WINDOW_RST 32'd64

// read-only id word ("RFLX")
`define REFLEX_ID_WORD 32'h52464C58

//////////////////////////////////////////////////////////////////////
// neuron model constants
//////////////////////////////////////////////////////////////////////

// current step per presynaptic spike
`define REFLEX_SPIKE_WEIGHT 32'sd256

// synaptic decay is i - (i >>> shift)
`define REFLEX_DECAY_SHIFT 3

// membrane leak is v >>> shift per cycle
`define REFLEX_LEAK_SHIFT 4

`endif

//--- reflex_pkg.sv
`include "reflex_macros.svh"

package reflex_pkg;

    //////////////////////////////////////////////////////////////////////
    // wishbone classic slave port
    //////////////////////////////////////////////////////////////////////

    // master to slave, held until ack
    typedef struct packed {
        logic                       cyc;
        logic                       stb;
        logic                       we;
        logic [`REFLEX_ADR_W-1:0]   adr;
        logic [`REFLEX_DATA_W-1:0]  dat;
    } wb_req_t;

    // slave to master
    // dat only meaningful while ack is high
    typedef struct packed {
        logic                       ack;
        logic [`REFLEX_DATA_W-1:0]  dat;
    } wb_rsp_t;

    //////////////////////////////////////////////////////////////////////
    // host configuration of the loop
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        // scales the summed synaptic current
        logic signed [`REFLEX_DATA_W-1:0]   gain;
        // membrane level that fires the motor neuron
        logic signed [`REFLEX_DATA_W-1:0]   threshold;
        // spike counting window, never 0
        logic        [`REFLEX_DATA_W-1:0]   window_len;
    } loop_cfg_t;

    // register map
    typedef enum logic [`REFLEX_ADR_W-1:0] {
        reg_gain      = 2'd0,
        reg_threshold = 2'd1,
        reg_window    = 2'd2,
        reg_id        = 2'd3
    } reg_addr_e;

endpackage

//--- reflex_synapse.sv
`timescale 1ns/100ps
`include "reflex_macros.svh"

module reflex_synapse
(
    input  logic                              ep50trig,
    input  logic                              reset_sim,
    // presynaptic spike, one cycle per event
    input  logic                              i_spike,
    output logic signed [`REFLEX_DATA_W-1:0]  o_current
);

    logic signed [`REFLEX_DATA_W-1:0] current_q;
    // exponential decay term
    logic signed [`REFLEX_DATA_W-1:0] decay;
    // weight added this cycle
    logic signed [`REFLEX_DATA_W-1:0] kick;
    logic signed [`REFLEX_DATA_W-1:0] current_nxt;

    //////////////////////////////////////////////////////////////////////
    // current update
    //////////////////////////////////////////////////////////////////////

    // arithmetic shift keeps sign of the current
    assign decay       = current_q >>> `REFLEX_DECAY_SHIFT;
    assign kick        = i_spike ? `REFLEX_SPIKE_WEIGHT : '0;
    assign current_nxt = current_q - decay + kick;

    // spike at edge k shows at edge k
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
            current_q <= '0;
        else
            current_q <= current_nxt;
    end

    assign o_current = current_q;

endmodule

//--- reflex_regbank.sv
`timescale 1ns/100ps
`include "reflex_macros.svh"

module reflex_regbank
    import reflex_pkg::*;
(
    input  logic      ep50trig,
    input  logic      reset_sim,
    input  wb_req_t   i_wb,
    output wb_rsp_t   o_wb,
    output loop_cfg_t o_cfg
);

    // address as register name
    reg_addr_e                  addr;
    // first edge of a cycle not yet acked
    logic                       access;
    logic                       ack_q;
    logic [`REFLEX_DATA_W-1:0]  rdata_q;
    logic [`REFLEX_DATA_W-1:0]  rdata_mux;
    loop_cfg_t                  cfg_q;

    assign addr   = reg_addr_e'(i_wb.adr);
    assign access = i_wb.cyc & i_wb.stb & ~ack_q;

    //////////////////////////////////////////////////////////////////////
    // read mux
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (addr)
            reg_gain:      rdata_mux = cfg_q.gain;
            reg_threshold: rdata_mux = cfg_q.threshold;
            reg_window:    rdata_mux = cfg_q.window_len;
            default:       rdata_mux = `REFLEX_ID_WORD;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // ack, writes and read data
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            ack_q            <= 1'b0;
            rdata_q          <= '0;
            cfg_q.gain       <= `REFLEX_GAIN_RST;
            cfg_q.threshold  <= `REFLEX_THRESH_RST;
            cfg_q.window_len <= `REFLEX_WINDOW_RST;
        end
        else
        begin
            // one wait state, ack for a single cycle
            ack_q <= access;
            if (access && i_wb.we)
            begin
                case (addr)
                    reg_gain:
                        cfg_q.gain <= $signed(i_wb.dat);
                    reg_threshold:
                        cfg_q.threshold <= $signed(i_wb.dat);
                    reg_window:
                    begin
                        // zero window would never close
                        if (i_wb.dat == '0)
                            cfg_q.window_len <= 32'd1;
                        else
                            cfg_q.window_len <= i_wb.dat;
                    end
                    // id is read only
                    default: ;
                endcase
            end
            // read data captured with the ack
            if (access && !i_wb.we)
                rdata_q <= rdata_mux;
        end
    end

    assign o_wb.ack = ack_q;
    assign o_wb.dat = rdata_q;
    assign o_cfg    = cfg_q;

endmodule

//--- reflex_motor_neuron.sv
`timescale 1ns/100ps
`include "reflex_macros.svh"

module reflex_motor_neuron
    import reflex_pkg::*;
(
    input  logic                              ep50trig,
    input  logic                              reset_sim,
    input  logic signed [`REFLEX_DATA_W-1:0]  i_syn_spinal,
    input  logic signed [`REFLEX_DATA_W-1:0]  i_syn_cortical,
    input  loop_cfg_t                         i_cfg,
    // gain scaled current for host readout
    output logic signed [`REFLEX_DATA_W-1:0]  o_drive,
    output logic                              o_spike
);

    // spinal plus transcortical current
    logic signed [`REFLEX_DATA_W-1:0]    syn_sum;
    // full product before truncation
    logic signed [2*`REFLEX_DATA_W-1:0]  drive_wide;
    logic signed [`REFLEX_DATA_W-1:0]    drive;
    logic signed [`REFLEX_DATA_W-1:0]    v_q;
    logic signed [`REFLEX_DATA_W-1:0]    leak;
    logic signed [`REFLEX_DATA_W-1:0]    v_nxt;
    logic                                fire;
    logic                                spike_q;

    //////////////////////////////////////////////////////////////////////
    // synaptic gain
    //////////////////////////////////////////////////////////////////////

    // currents added, never or'ed as spikes
    assign syn_sum    = i_syn_spinal + i_syn_cortical;
    assign drive_wide = syn_sum * $signed(i_cfg.gain);
    // low word kept as a signed value
    assign drive      = $signed(drive_wide[`REFLEX_DATA_W-1:0]);

    //////////////////////////////////////////////////////////////////////
    // leaky integrate and fire
    //////////////////////////////////////////////////////////////////////

    assign leak  = v_q >>> `REFLEX_LEAK_SHIFT;
    assign v_nxt = v_q + drive - leak;
    // signed compare against threshold
    assign fire  = (v_nxt >= $signed(i_cfg.threshold));

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            v_q     <= '0;
            spike_q <= 1'b0;
        end
        else
        begin
            // membrane drops to rest on a spike
            v_q     <= fire ? '0 : v_nxt;
            spike_q <= fire;
        end
    end

    assign o_drive = drive;
    assign o_spike = spike_q;

endmodule

//--- reflex_spike_window_counter.sv
`timescale 1ns/100ps
`include "reflex_macros.svh"

module reflex_spike_window_counter
    import reflex_pkg::*;
(
    input  logic                       ep50trig,
    input  logic                       reset_sim,
    // motor neuron spike pulse
    input  logic                       i_spike,
    input  loop_cfg_t                  i_cfg,
    // total of the last closed window
    output logic [`REFLEX_DATA_W-1:0]  o_count,
    output logic                       o_count_valid
);

    // cycle within the window
    logic [`REFLEX_DATA_W-1:0] index_q;
    logic [`REFLEX_DATA_W-1:0] run_q;
    // running total including this edge
    logic [`REFLEX_DATA_W-1:0] run_inc;
    logic                      last;
    logic [`REFLEX_DATA_W-1:0] count_q;
    logic                      valid_q;

    //////////////////////////////////////////////////////////////////////
    // window end detect
    //////////////////////////////////////////////////////////////////////

    assign run_inc = run_q + {{(`REFLEX_DATA_W-1){1'b0}}, i_spike};
    // window_len is never 0 so no underflow
    // shrinking the window below index closes it at once
    assign last    = (index_q >= i_cfg.window_len - 32'd1);

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            index_q <= '0;
            run_q   <= '0;
            count_q <= '0;
            valid_q <= 1'b0;
        end
        else
        begin
            if (last)
            begin
                // present the total and restart
                count_q <= run_inc;
                valid_q <= 1'b1;
                index_q <= '0;
                run_q   <= '0;
            end
            else
            begin
                valid_q <= 1'b0;
                index_q <= index_q + 32'd1;
                run_q   <= run_inc;
            end
        end
    end

    assign o_count       = count_q;
    assign o_count_valid = valid_q;

endmodule

//--- reflex_loop_top.sv
`timescale 1ns/100ps
`include "reflex_macros.svh"

module reflex_loop_top
    import reflex_pkg::*;
(
    input  logic                              ep50trig,
    input  logic                              reset_sim,
    // spinal sensory neuron spikes
    input  logic                              i_spike_spinal,
    // cross-board cortical spikes
    input  logic                              i_spike_cortical,
    input  wb_req_t                           i_wb,
    output wb_rsp_t                           o_wb,
    output logic signed [`REFLEX_DATA_W-1:0]  o_drive,
    output logic                              o_mn_spike,
    output logic [`REFLEX_DATA_W-1:0]         o_count,
    output logic                              o_count_valid
);

    loop_cfg_t                         cfg;
    logic signed [`REFLEX_DATA_W-1:0]  syn_spinal;
    logic signed [`REFLEX_DATA_W-1:0]  syn_cortical;
    logic                              mn_spike;

    //////////////////////////////////////////////////////////////////////
    // host registers
    //////////////////////////////////////////////////////////////////////

    reflex_regbank regbank_i
    (
        .ep50trig  (ep50trig),
        .reset_sim (reset_sim),
        .i_wb      (i_wb),
        .o_wb      (o_wb),
        .o_cfg     (cfg)
    );

    //////////////////////////////////////////////////////////////////////
    // synapses
    //////////////////////////////////////////////////////////////////////

    // short latency path
    reflex_synapse syn_spinal_i
    (
        .ep50trig  (ep50trig),
        .reset_sim (reset_sim),
        .i_spike   (i_spike_spinal),
        .o_current (syn_spinal)
    );

    // long latency transcortical path
    reflex_synapse syn_cortical_i
    (
        .ep50trig  (ep50trig),
        .reset_sim (reset_sim),
        .i_spike   (i_spike_cortical),
        .o_current (syn_cortical)
    );

    //////////////////////////////////////////////////////////////////////
    // motor neuron and spike count
    //////////////////////////////////////////////////////////////////////

    reflex_motor_neuron motor_neuron_i
    (
        .ep50trig       (ep50trig),
        .reset_sim      (reset_sim),
        .i_syn_spinal   (syn_spinal),
        .i_syn_cortical (syn_cortical),
        .i_cfg          (cfg),
        .o_drive        (o_drive),
        .o_spike        (mn_spike)
    );

    reflex_spike_window_counter spike_cnt_i
    (
        .ep50trig      (ep50trig),
        .reset_sim     (reset_sim),
        .i_spike       (mn_spike),
        .i_cfg         (cfg),
        .o_count       (o_count),
        .o_count_valid (o_count_valid)
    );

    // motor neuron spike also leaves the chip
    assign o_mn_spike = mn_spike;

endmodule

//--- tb_reflex_loop.sv
`timescale 1ns/100ps
`include "reflex_macros.svh"

module tb_reflex_loop
    import reflex_pkg::*;
();

    logic                              ep50trig = 1'b0;
    logic                              reset_sim;
    logic                              i_spike_spinal;
    logic                              i_spike_cortical;
    wb_req_t                           wb_req;
    wb_rsp_t                           wb_rsp;
    logic signed [`REFLEX_DATA_W-1:0]  drive;
    logic                              mn_spike;
    logic [`REFLEX_DATA_W-1:0]         count;
    logic                              count_valid;

    // separate random streams for spikes and register values
    logic [31:0] spike_rng;
    logic [31:0] cfg_rng;
    logic        spikes_on;
    logic        timed_out;
    int          cycle_cnt;
    int          word_errs, drive_errs, bit_errs, rsp_errs, timeouts;

    // reference model copy of every register in the loop
    loop_cfg_t                         m_cfg;
    logic signed [`REFLEX_DATA_W-1:0]  m_sp, m_co, m_v;
    logic                              m_spike, m_ack, m_valid;
    logic [`REFLEX_DATA_W-1:0]         m_idx, m_run, m_count;

    reflex_loop_top reflex_loop_top_i
    (
        .ep50trig         (ep50trig),
        .reset_sim        (reset_sim),
        .i_spike_spinal   (i_spike_spinal),
        .i_spike_cortical (i_spike_cortical),
        .i_wb             (wb_req),
        .o_wb             (wb_rsp),
        .o_drive          (drive),
        .o_mn_spike       (mn_spike),
        .o_count          (count),
        .o_count_valid    (count_valid)
    );

    // 40 ns period
    always #20 ep50trig = ~ep50trig;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // summed current times gain truncated to the low word
    function automatic logic signed [31:0] model_drive(input logic signed [31:0] a,
                                                       input logic signed [31:0] b,
                                                       input logic signed [31:0] g);
        logic signed [31:0] s;
        logic signed [63:0] p;
        s = a + b;
        p = longint'(s) * longint'(g);
        return p[31:0];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    task automatic reset_model();
        m_cfg.gain       = 32'sd1;
        m_cfg.threshold  = 32'sd4096;
        m_cfg.window_len = 32'd64;
        m_sp    = '0;
        m_co    = '0;
        m_v     = '0;
        m_spike = 1'b0;
        m_ack   = 1'b0;
        m_valid = 1'b0;
        m_idx   = '0;
        m_run   = '0;
        m_count = '0;
    endtask

    task automatic step_model();
        logic signed [31:0] drv;
        logic signed [31:0] v_next;
        logic               fire;
        logic [31:0]        run_inc;
        logic               win_end;
        logic               access;
        // everything below sees the state from before this edge
        drv     = model_drive(m_sp, m_co, m_cfg.gain);
        v_next  = m_v + drv - (m_v >>> `REFLEX_LEAK_SHIFT);
        fire    = (v_next >= $signed(m_cfg.threshold));
        run_inc = m_run + {31'b0, m_spike};
        // last cycle or window shrunk below the index
        win_end = (m_idx == m_cfg.window_len - 32'd1) || (m_cfg.window_len <= m_idx);
        access  = wb_req.cyc & wb_req.stb & ~m_ack;
        if (win_end)
        begin
            m_count = run_inc;
            m_valid = 1'b1;
            m_idx   = '0;
            m_run   = '0;
        end
        else
        begin
            m_valid = 1'b0;
            m_idx   = m_idx + 32'd1;
            m_run   = run_inc;
        end
        m_v     = fire ? 32'sd0 : v_next;
        m_spike = fire;
        m_sp = m_sp - (m_sp >>> `REFLEX_DECAY_SHIFT)
             + (i_spike_spinal ? `REFLEX_SPIKE_WEIGHT : 32'sd0);
        m_co = m_co - (m_co >>> `REFLEX_DECAY_SHIFT)
             + (i_spike_cortical ? `REFLEX_SPIKE_WEIGHT : 32'sd0);
        // register writes land after the neuron used the old config
        if (access && wb_req.we)
        begin
            case (reg_addr_e'(wb_req.adr))
                reg_gain:      m_cfg.gain = wb_req.dat;
                reg_threshold: m_cfg.threshold = wb_req.dat;
                reg_window:    m_cfg.window_len = (wb_req.dat == 32'd0) ? 32'd1 : wb_req.dat;
                default:       ;
            endcase
        end
        m_ack = access;
    endtask

    always @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
            reset_model();
        else
            step_model();
    end

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
        begin
            word_errs++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_drive(input string name, input logic signed [31:0] exp,
                               input logic signed [31:0] act);
        if (exp !== act)
        begin
            drive_errs++;
            $display("error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            bit_errs++;
            $display("error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_rsp(input string name, input wb_rsp_t exp, input wb_rsp_t act);
        if (exp !== act)
        begin
            rsp_errs++;
            $display("error %s: expected ack %b dat %h, actual ack %b dat %h",
                     name, exp.ack, exp.dat, act.ack, act.dat);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // cycle stepping and stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic compare_outputs();
        check_drive("drive", model_drive(m_sp, m_co, m_cfg.gain), drive);
        check_bit("mn_spike", m_spike, mn_spike);
        check_bit("count_valid", m_valid, count_valid);
        check_word("count", m_count, count);
        check_bit("wb_ack", m_ack, wb_rsp.ack);
    endtask

    // about one spike in 8 cycles on each input
    task automatic drive_spikes();
        if (spikes_on)
        begin
            spike_rng        = xorshift32(spike_rng);
            i_spike_spinal   = (spike_rng[2:0] == 3'd0);
            i_spike_cortical = (spike_rng[10:8] == 3'd0);
        end
        else
        begin
            i_spike_spinal   = 1'b0;
            i_spike_cortical = 1'b0;
        end
    endtask

    // sample at +1 ns and drive at +2 ns
    task automatic next_cycle();
        @(posedge ep50trig);
        #1;
        cycle_cnt++;
        if (!reset_sim)
            compare_outputs();
        #1;
        drive_spikes();
    endtask

    task automatic run_cycles(input int n);
        for (int k = 0; k < n && cycle_cnt < 4000 && !timed_out; k++)
            next_cycle();
    endtask

    // single wishbone cycle held until ack
    task automatic wb_access(input reg_addr_e adr, input logic we, input logic [31:0] dat,
                             output wb_rsp_t rsp);
        int   waited;
        logic got;
        rsp    = '0;
        waited = 0;
        got    = 1'b0;
        if (timed_out)
            return;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        while (!got && waited < 20)
        begin
            next_cycle();
            waited++;
            if (wb_rsp.ack)
            begin
                got = 1'b1;
                rsp = wb_rsp;
            end
        end
        wb_req = '0;
        if (!got)
        begin
            timeouts++;
            timed_out = 1'b1;
            $display("timeout: no wishbone ack within 20 cycles at address %0d", adr);
        end
        else
        begin
            // ack must drop right after
            next_cycle();
            check_bit("wb_ack_single", 1'b0, wb_rsp.ack);
        end
    endtask

    task automatic wb_write(input reg_addr_e adr, input logic [31:0] dat);
        wb_rsp_t rsp;
        wb_access(adr, 1'b1, dat, rsp);
    endtask

    task automatic wb_read_check(input string name, input reg_addr_e adr,
                                 input logic [31:0] expv);
        wb_rsp_t rsp;
        wb_rsp_t exp_rsp;
        exp_rsp.ack = 1'b1;
        exp_rsp.dat = expv;
        wb_access(adr, 1'b0, 32'd0, rsp);
        check_rsp(name, exp_rsp, rsp);
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        reset_sim        = 1'b1;
        i_spike_spinal   = 1'b0;
        i_spike_cortical = 1'b0;
        wb_req           = '0;
        spikes_on        = 1'b0;
        timed_out        = 1'b0;
        spike_rng        = 32'd1880;
        cfg_rng          = ~32'd1880;
        cycle_cnt        = 0;
        word_errs        = 0;
        drive_errs       = 0;
        bit_errs         = 0;
        rsp_errs         = 0;
        timeouts         = 0;
        repeat (10) next_cycle();
        reset_sim = 1'b0;

        // outputs idle after reset
        check_drive("rst_drive", 32'sd0, drive);
        check_bit("rst_mn_spike", 1'b0, mn_spike);
        check_bit("rst_count_valid", 1'b0, count_valid);
        check_word("rst_count", 32'd0, count);
        wb_read_check("rst_gain", reg_gain, 32'd1);
        wb_read_check("rst_threshold", reg_threshold, 32'd4096);
        wb_read_check("rst_window", reg_window, 32'd64);
        wb_read_check("rst_id", reg_id, 32'h52464C58);

        // write then read back
        wb_write(reg_gain, 32'd5);
        wb_read_check("rw_gain", reg_gain, 32'd5);
        cfg_rng = xorshift32(cfg_rng);
        wb_write(reg_threshold, cfg_rng);
        wb_read_check("rw_threshold", reg_threshold, cfg_rng);
        wb_write(reg_window, 32'd37);
        wb_read_check("rw_window", reg_window, 32'd37);
        wb_write(reg_window, 32'd0);
        wb_read_check("rw_window_zero", reg_window, 32'd1);
        wb_write(reg_id, 32'd0);
        wb_read_check("rw_id", reg_id, 32'h52464C58);

        // random spikes under the reset config
        wb_write(reg_gain, 32'd1);
        wb_write(reg_threshold, 32'd4096);
        wb_write(reg_window, 32'd64);
        spikes_on = 1'b1;
        run_cycles(1000);

        // gain from -4 to 12 and threshold 500 and up
        repeat (6)
        begin
            cfg_rng = xorshift32(cfg_rng);
            wb_write(reg_gain, (cfg_rng % 32'd17) - 32'd4);
            cfg_rng = xorshift32(cfg_rng);
            wb_write(reg_threshold, 32'd500 + (cfg_rng % 32'd19500));
            run_cycles(200);
        end

        // windows of 1 to 100 cycles
        wb_write(reg_gain, 32'd2);
        wb_write(reg_threshold, 32'd4096);
        while (cycle_cnt < 4000 && !timed_out)
        begin
            cfg_rng = xorshift32(cfg_rng);
            wb_write(reg_window, 32'd1 + (cfg_rng % 32'd100));
            run_cycles(150);
        end

        $display("errors: word %0d, drive %0d, bit %0d, rsp %0d, timeout %0d",
                 word_errs, drive_errs, bit_errs, rsp_errs, timeouts);
        if (word_errs + drive_errs + bit_errs + rsp_errs + timeouts == 0 && !timed_out)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
reflex_pkg.sv
reflex_synapse.sv
reflex_regbank.sv
reflex_motor_neuron.sv
reflex_spike_window_counter.sv
reflex_loop_top.sv
tb_reflex_loop.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/100ps -j 0
TOP       = tb_reflex_loop
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
